//--- Bender.yml
package:
  name: cce

sources:
  - files:
      - rtl/cce_pkg.sv
      - rtl/cce_inst_pkg.sv
      - rtl/cce_pc_rom.sv
      - rtl/cce_inst_decode.sv
      - rtl/cce_alu.sv
      - rtl/cce_reg.sv
      - rtl/cce_cmd_former.sv
      - rtl/cce_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cce.sv

//--- filelist.f
+incdir+test
rtl/cce_pkg.sv
rtl/cce_inst_pkg.sv
rtl/cce_pc_rom.sv
rtl/cce_inst_decode.sv
rtl/cce_alu.sv
rtl/cce_reg.sv
rtl/cce_cmd_former.sv
rtl/cce_top.sv
test/tb_cce.sv

//--- rtl/cce_alu.sv
// CCE ALU with operand select, computing mov and add results and the branch compare
`timescale 1ns/1ps
`default_nettype none

module cce_alu
  import cce_pkg::*;
  import cce_inst_pkg::*;
  #(parameter int num_lce_p = 4
    , localparam int lce_id_width_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
  )
  (input wire src_sel_e                    src_a_i
   , input wire src_sel_e                  src_b_i
   , input wire [IMM_WIDTH-1:0]            imm_i
   , input wire opcode_e                   opcode_i
   , input wire [GPR_WIDTH-1:0]            r0_i
   , input wire [GPR_WIDTH-1:0]            r1_i
   , input wire [lce_id_width_lp-1:0]      req_lce_i
   , input wire req_type_e                 req_type_i
   , input wire                            lce_req_v_i
   , output logic [GPR_WIDTH-1:0]          alu_res_o
   , output logic                          branch_taken_o
  );

  // One entry per source select, shared by both operands
  logic [GPR_WIDTH-1:0] src_val [2**SRC_WIDTH];
  logic [GPR_WIDTH-1:0] opd_a;
  logic [GPR_WIDTH-1:0] opd_b;

  always_comb begin
    src_val                  = '{default: '0};
    src_val[e_src_r0]        = r0_i;
    src_val[e_src_r1]        = r1_i;
    src_val[e_src_req_lce]   = {{(GPR_WIDTH-lce_id_width_lp){1'b0}}, req_lce_i};
    src_val[e_src_rqf]       = {{(GPR_WIDTH-1){1'b0}}, req_type_i};
    src_val[e_src_lce_req_v] = {{(GPR_WIDTH-1){1'b0}}, lce_req_v_i};
    src_val[e_src_imm]       = imm_i;
  end

  assign opd_a = src_val[src_a_i];
  assign opd_b = src_val[src_b_i];

  always_comb begin
    case (opcode_i)
      e_op_beq: branch_taken_o = (opd_a == opd_b);
      e_op_bne: branch_taken_o = (opd_a != opd_b);
      default:  branch_taken_o = 1'b0;
    endcase
    // mov passes operand a through
    alu_res_o = (opcode_i == e_op_add) ? opd_a + opd_b : opd_a;
  end

endmodule

`default_nettype wire

//--- rtl/cce_cmd_former.sv
// CCE command former, builds outbound LCE command fields from the request and GPR state
`timescale 1ns/1ps
`default_nettype none

module cce_cmd_former
  import cce_pkg::*;
  #(parameter int num_lce_p      = 4
    , parameter int addr_width_p = 32
    , localparam int lce_id_width_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
  )
  (input wire lce_cmd_e                    cmd_type_i
   , input wire [GPR_WIDTH-1:0]            r1_i
   , input wire [lce_id_width_lp-1:0]      req_lce_i
   , input wire [addr_width_p-1:0]         req_addr_i
   , input wire req_type_e                 req_type_i
   , output logic [lce_id_width_lp-1:0]    lce_cmd_dst_o
   , output lce_cmd_e                      lce_cmd_type_o
   , output logic [addr_width_p-1:0]       lce_cmd_addr_o
   , output coh_state_e                    lce_cmd_state_o
  );

  assign lce_cmd_type_o = cmd_type_i;
  assign lce_cmd_addr_o = req_addr_i;

  always_comb begin
    if (cmd_type_i == e_lce_cmd_set_tag) begin
      lce_cmd_dst_o   = req_lce_i;
      lce_cmd_state_o = (req_type_i == e_req_wr) ? e_coh_exclusive : e_coh_shared;
    end else begin
      // Invalidate walk target lives in r1
      lce_cmd_dst_o   = r1_i[lce_id_width_lp-1:0];
      lce_cmd_state_o = e_coh_invalid;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cce_inst_decode.sv
// CCE instruction decoder, turns the current opcode into queue strobes, stalls and branches
`timescale 1ns/1ps
`default_nettype none

module cce_inst_decode
  import cce_pkg::*;
  import cce_inst_pkg::*;
  (input wire opcode_e                 opcode_i
   , input wire [IMM_WIDTH-1:0]        imm_i
   , input wire                        lce_req_v_i
   , input wire                        lce_cmd_ready_i
   , input wire                        branch_taken_i
   , output logic                      pc_stall_o
   , output logic                      branch_v_o
   , output logic                      req_capture_o
   , output logic                      gpr_w_v_o
   , output logic                      lce_req_yumi_o
   , output logic                      lce_cmd_v_o
   , output lce_cmd_e                  cmd_type_o
  );

  always_comb begin
    pc_stall_o     = 1'b0;
    branch_v_o     = 1'b0;
    req_capture_o  = 1'b0;
    gpr_w_v_o      = 1'b0;
    lce_req_yumi_o = 1'b0;
    lce_cmd_v_o    = 1'b0;
    case (opcode_i)
      e_op_wait_req: pc_stall_o = !lce_req_v_i;
      // Yumi only while the request is valid
      e_op_pop_req: begin
        pc_stall_o     = !lce_req_v_i;
        lce_req_yumi_o = lce_req_v_i;
        req_capture_o  = lce_req_v_i;
      end
      e_op_mov, e_op_add: gpr_w_v_o = 1'b1;
      e_op_beq, e_op_bne: branch_v_o = branch_taken_i;
      e_op_jump: branch_v_o = 1'b1;
      // Hold the instruction until the command is accepted
      e_op_push_cmd: begin
        lce_cmd_v_o = 1'b1;
        pc_stall_o  = !lce_cmd_ready_i;
      end
      default: pc_stall_o = 1'b0;
    endcase
  end

  // Command type is carried in the immediate of push_cmd
  assign cmd_type_o = lce_cmd_e'(imm_i[$bits(lce_cmd_e)-1:0]);

endmodule

`default_nettype wire

//--- rtl/cce_inst_pkg.sv
// CCE microcode types: opcodes, operand sources, write-back targets and field widths
`default_nettype none

package cce_inst_pkg;

  import cce_pkg::*;

  // Instruction field widths
  localparam int OPCODE_WIDTH    = 4;
  localparam int SRC_WIDTH       = 3;
  localparam int DST_WIDTH       = 1;
  localparam int INST_ADDR_WIDTH = 4;
  localparam int IMM_WIDTH       = GPR_WIDTH;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    e_op_wait_req = 4'd0,
    e_op_pop_req  = 4'd1,
    e_op_mov      = 4'd2,
    e_op_add      = 4'd3,
    e_op_beq      = 4'd4,
    e_op_bne      = 4'd5,
    e_op_jump     = 4'd6,
    e_op_push_cmd = 4'd7
  } opcode_e;

  // ALU operand sources, narrow ones are zero extended
  typedef enum logic [SRC_WIDTH-1:0] {
    e_src_r0        = 3'd0,
    e_src_r1        = 3'd1,
    e_src_req_lce   = 3'd2,
    e_src_rqf       = 3'd3,
    e_src_lce_req_v = 3'd4,
    e_src_imm       = 3'd5,
    e_src_const_0   = 3'd6
  } src_sel_e;

  typedef enum logic [DST_WIDTH-1:0] {
    e_dst_r0 = 1'b0,
    e_dst_r1 = 1'b1
  } dst_sel_e;

endpackage

`default_nettype wire

//--- rtl/cce_pc_rom.sv
// CCE program counter with stall and branch, reading the fixed coherence microcode ROM
`timescale 1ns/1ps
`default_nettype none

module cce_pc_rom
  import cce_pkg::*;
  import cce_inst_pkg::*;
  #(parameter int num_lce_p = 4)
  (input wire                            clk_i
   , input wire                          arst_n_i
   , input wire                          pc_stall_i
   , input wire                          branch_v_i
   , output opcode_e                     opcode_o
   , output src_sel_e                    src_a_o
   , output src_sel_e                    src_b_o
   , output dst_sel_e                    dst_o
   , output logic [IMM_WIDTH-1:0]        imm_o
   , output logic [INST_ADDR_WIDTH-1:0]  target_o
  );

  // Branch targets inside the program
  localparam logic [INST_ADDR_WIDTH-1:0] wait_addr_lp    = 0;
  localparam logic [INST_ADDR_WIDTH-1:0] inv_loop_addr_lp = 4;
  localparam logic [INST_ADDR_WIDTH-1:0] next_lce_addr_lp = 6;
  localparam logic [INST_ADDR_WIDTH-1:0] set_tag_addr_lp = 8;

  logic [INST_ADDR_WIDTH-1:0] pc_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_r <= '0;
    end else if (pc_stall_i) begin
      pc_r <= pc_r;
    end else if (branch_v_i) begin
      pc_r <= target_o;
    end else begin
      pc_r <= pc_r + 1'b1;
    end
  end

  // Unused entries jump back to the wait loop
  always_comb begin
    opcode_o = e_op_jump;
    src_a_o  = e_src_const_0;
    src_b_o  = e_src_const_0;
    dst_o    = e_dst_r0;
    imm_o    = '0;
    target_o = wait_addr_lp;
    case (pc_r)
      INST_ADDR_WIDTH'(0): opcode_o = e_op_wait_req;
      INST_ADDR_WIDTH'(1): opcode_o = e_op_pop_req;
      // Reads skip the invalidate walk
      INST_ADDR_WIDTH'(2): begin
        opcode_o = e_op_beq;
        src_a_o  = e_src_rqf;
        target_o = set_tag_addr_lp;
      end
      INST_ADDR_WIDTH'(3): begin
        opcode_o = e_op_mov;
        dst_o    = e_dst_r1;
      end
      // Requester keeps its copy
      INST_ADDR_WIDTH'(4): begin
        opcode_o = e_op_beq;
        src_a_o  = e_src_r1;
        src_b_o  = e_src_req_lce;
        target_o = next_lce_addr_lp;
      end
      INST_ADDR_WIDTH'(5): begin
        opcode_o = e_op_push_cmd;
        imm_o    = IMM_WIDTH'(e_lce_cmd_invalidate);
      end
      INST_ADDR_WIDTH'(6): begin
        opcode_o = e_op_add;
        src_a_o  = e_src_r1;
        src_b_o  = e_src_imm;
        dst_o    = e_dst_r1;
        imm_o    = IMM_WIDTH'(1);
      end
      INST_ADDR_WIDTH'(7): begin
        opcode_o = e_op_bne;
        src_a_o  = e_src_r1;
        src_b_o  = e_src_imm;
        imm_o    = IMM_WIDTH'(num_lce_p);
        target_o = inv_loop_addr_lp;
      end
      INST_ADDR_WIDTH'(8): begin
        opcode_o = e_op_push_cmd;
        imm_o    = IMM_WIDTH'(e_lce_cmd_set_tag);
      end
      default: opcode_o = e_op_jump;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/cce_pkg.sv
// CCE protocol types shared by the datapath and the LCE-facing ports
`default_nettype none

package cce_pkg;

  // GPR and ALU datapath width
  localparam int GPR_WIDTH = 8;

  // Coherence state carried in set-tag commands
  typedef enum logic [1:0] {
    e_coh_invalid   = 2'd0,
    e_coh_shared    = 2'd1,
    e_coh_exclusive = 2'd2
  } coh_state_e;

  // LCE request type, doubles as the request-type flag
  typedef enum logic {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } req_type_e;

  // LCE command type, two bits leave room for more commands
  typedef enum logic [1:0] {
    e_lce_cmd_set_tag    = 2'd0,
    e_lce_cmd_invalidate = 2'd1
  } lce_cmd_e;

endpackage

`default_nettype wire

//--- rtl/cce_reg.sv
// CCE register block holding the captured request, the request-type flag and two GPRs
`timescale 1ns/1ps
`default_nettype none

module cce_reg
  import cce_pkg::*;
  import cce_inst_pkg::*;
  #(parameter int num_lce_p      = 4
    , parameter int addr_width_p = 32
    , localparam int lce_id_width_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
  )
  (input wire                              clk_i
   , input wire                            arst_n_i
   , input wire                            req_capture_i
   , input wire                            gpr_w_v_i
   , input wire dst_sel_e                  dst_i
   , input wire [GPR_WIDTH-1:0]            alu_res_i
   , input wire [lce_id_width_lp-1:0]      lce_req_lce_i
   , input wire req_type_e                 lce_req_type_i
   , input wire [addr_width_p-1:0]         lce_req_addr_i
   , output logic [lce_id_width_lp-1:0]    req_lce_o
   , output logic [addr_width_p-1:0]       req_addr_o
   , output req_type_e                     req_type_o
   , output logic [GPR_WIDTH-1:0]          r0_o
   , output logic [GPR_WIDTH-1:0]          r1_o
  );

  logic [1:0][GPR_WIDTH-1:0] gpr_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_lce_o  <= '0;
      req_addr_o <= '0;
      req_type_o <= e_req_rd;
    end else if (req_capture_i) begin
      req_lce_o  <= lce_req_lce_i;
      req_addr_o <= lce_req_addr_i;
      req_type_o <= lce_req_type_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpr_r <= '0;
    end else if (gpr_w_v_i) begin
      gpr_r[dst_i] <= alu_res_i;
    end
  end

  assign r0_o = gpr_r[e_dst_r0];
  assign r1_o = gpr_r[e_dst_r1];

endmodule

`default_nettype wire

//--- rtl/cce_top.sv
// CCE top level, connects the microcode sequencer, decoder, ALU, registers and command former
`timescale 1ns/1ps
`default_nettype none

module cce_top
  import cce_pkg::*;
  import cce_inst_pkg::*;
  #(parameter int num_lce_p      = 4
    , parameter int addr_width_p = 32
    , localparam int lce_id_width_lp = (num_lce_p > 1) ? $clog2(num_lce_p) : 1
  )
  (input wire                             clk_i
   , input wire                           arst_n_i

   // Inbound LCE requests, valid->yumi
   , input wire                           lce_req_v_i
   , input wire [lce_id_width_lp-1:0]     lce_req_lce_i
   , input wire req_type_e                lce_req_type_i
   , input wire [addr_width_p-1:0]        lce_req_addr_i
   , output logic                         lce_req_yumi_o

   // Outbound LCE commands, valid->ready
   , output logic                         lce_cmd_v_o
   , input wire                           lce_cmd_ready_i
   , output logic [lce_id_width_lp-1:0]   lce_cmd_dst_o
   , output lce_cmd_e                     lce_cmd_type_o
   , output logic [addr_width_p-1:0]      lce_cmd_addr_o
   , output coh_state_e                   lce_cmd_state_o
  );

  opcode_e                    opcode;
  src_sel_e                   src_a;
  src_sel_e                   src_b;
  dst_sel_e                   dst;
  logic [IMM_WIDTH-1:0]       imm;
  logic [INST_ADDR_WIDTH-1:0] target;

  logic pc_stall;
  logic branch_v;
  logic req_capture;
  logic gpr_w_v;
  logic branch_taken;
  lce_cmd_e cmd_type;

  logic [GPR_WIDTH-1:0]       alu_res;
  logic [GPR_WIDTH-1:0]       r0;
  logic [GPR_WIDTH-1:0]       r1;
  logic [lce_id_width_lp-1:0] req_lce;
  logic [addr_width_p-1:0]    req_addr;
  req_type_e                  req_type;

  cce_pc_rom
    #(.num_lce_p(num_lce_p))
    pc_rom
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.pc_stall_i(pc_stall)
      ,.branch_v_i(branch_v)
      ,.opcode_o(opcode)
      ,.src_a_o(src_a)
      ,.src_b_o(src_b)
      ,.dst_o(dst)
      ,.imm_o(imm)
      ,.target_o(target)
      );

  cce_inst_decode
    inst_decode
     (.opcode_i(opcode)
      ,.imm_i(imm)
      ,.lce_req_v_i(lce_req_v_i)
      ,.lce_cmd_ready_i(lce_cmd_ready_i)
      ,.branch_taken_i(branch_taken)
      ,.pc_stall_o(pc_stall)
      ,.branch_v_o(branch_v)
      ,.req_capture_o(req_capture)
      ,.gpr_w_v_o(gpr_w_v)
      ,.lce_req_yumi_o(lce_req_yumi_o)
      ,.lce_cmd_v_o(lce_cmd_v_o)
      ,.cmd_type_o(cmd_type)
      );

  cce_alu
    #(.num_lce_p(num_lce_p))
    alu
     (.src_a_i(src_a)
      ,.src_b_i(src_b)
      ,.imm_i(imm)
      ,.opcode_i(opcode)
      ,.r0_i(r0)
      ,.r1_i(r1)
      ,.req_lce_i(req_lce)
      ,.req_type_i(req_type)
      ,.lce_req_v_i(lce_req_v_i)
      ,.alu_res_o(alu_res)
      ,.branch_taken_o(branch_taken)
      );

  cce_reg
    #(.num_lce_p(num_lce_p)
      ,.addr_width_p(addr_width_p))
    regs
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.req_capture_i(req_capture)
      ,.gpr_w_v_i(gpr_w_v)
      ,.dst_i(dst)
      ,.alu_res_i(alu_res)
      ,.lce_req_lce_i(lce_req_lce_i)
      ,.lce_req_type_i(lce_req_type_i)
      ,.lce_req_addr_i(lce_req_addr_i)
      ,.req_lce_o(req_lce)
      ,.req_addr_o(req_addr)
      ,.req_type_o(req_type)
      ,.r0_o(r0)
      ,.r1_o(r1)
      );

  cce_cmd_former
    #(.num_lce_p(num_lce_p)
      ,.addr_width_p(addr_width_p))
    cmd_former
     (.cmd_type_i(cmd_type)
      ,.r1_i(r1)
      ,.req_lce_i(req_lce)
      ,.req_addr_i(req_addr)
      ,.req_type_i(req_type)
      ,.lce_cmd_dst_o(lce_cmd_dst_o)
      ,.lce_cmd_type_o(lce_cmd_type_o)
      ,.lce_cmd_addr_o(lce_cmd_addr_o)
      ,.lce_cmd_state_o(lce_cmd_state_o)
      );

endmodule

`default_nettype wire

//--- test/tb_cce_ref.svh
// Reference model for the CCE, expands one LCE request into its expected command stream
`ifndef TB_CCE_REF_SVH
`define TB_CCE_REF_SVH

typedef struct packed {
  lce_cmd_e                   cmd_type;
  logic [lce_id_width_lp-1:0] dst;
  logic [addr_width_lp-1:0]   addr;
  coh_state_e                 state;
} exp_cmd_t;

typedef exp_cmd_t exp_list_t[$];

// Writes invalidate every other LCE in ascending order, then the requester gets a set-tag
function automatic exp_list_t expand_request(input logic [lce_id_width_lp-1:0] req_lce,
                                             input req_type_e req_type,
                                             input logic [addr_width_lp-1:0] addr);
  exp_list_t cmds;
  exp_cmd_t  cmd;
  if (req_type == e_req_wr) begin
    for (int i = 0; i < num_lce_lp; i++) begin
      if (i != int'(req_lce)) begin
        cmd.cmd_type = e_lce_cmd_invalidate;
        cmd.dst      = lce_id_width_lp'(i);
        cmd.addr     = addr;
        cmd.state    = e_coh_invalid;
        cmds.push_back(cmd);
      end
    end
  end
  cmd.cmd_type = e_lce_cmd_set_tag;
  cmd.dst      = req_lce;
  cmd.addr     = addr;
  // Writer gets the only copy
  cmd.state    = (req_type == e_req_wr) ? e_coh_exclusive : e_coh_shared;
  cmds.push_back(cmd);
  return cmds;
endfunction

`endif

//--- test/tb_cce.sv
// Testbench for the CCE, drives LCE requests with random back-pressure and checks the commands
`timescale 1ns/1ps
`default_nettype none

module tb_cce
  import cce_pkg::*;
  ();

  localparam int num_lce_lp       = 4;
  localparam int addr_width_lp    = 32;
  localparam int lce_id_width_lp  = $clog2(num_lce_lp);
  localparam int timeout_lp       = 2000;
  localparam int num_random_lp    = 200;
  localparam logic [31:0] seed_lp = 32'd50575;

  `include "tb_cce_ref.svh"

  logic                       clk_i = 1'b0;
  logic                       arst_n_i;
  logic                       lce_req_v_i;
  logic [lce_id_width_lp-1:0] lce_req_lce_i;
  req_type_e                  lce_req_type_i;
  logic [addr_width_lp-1:0]   lce_req_addr_i;
  logic                       lce_req_yumi_o;
  logic                       lce_cmd_v_o;
  logic                       lce_cmd_ready_i = 1'b0;
  logic [lce_id_width_lp-1:0] lce_cmd_dst_o;
  lce_cmd_e                   lce_cmd_type_o;
  logic [addr_width_lp-1:0]   lce_cmd_addr_o;
  coh_state_e                 lce_cmd_state_o;

  exp_cmd_t    exp_q[$];
  exp_cmd_t    held;
  bit          hold_pending = 1'b0;
  bit          random_ready = 1'b0;
  logic [31:0] stim_state = seed_lp;
  logic [31:0] ready_state = ~seed_lp;

  cce_top
    #(.num_lce_p(num_lce_lp)
      ,.addr_width_p(addr_width_lp))
    cce_top_inst
     (.clk_i(clk_i)
      ,.arst_n_i(arst_n_i)
      ,.lce_req_v_i(lce_req_v_i)
      ,.lce_req_lce_i(lce_req_lce_i)
      ,.lce_req_type_i(lce_req_type_i)
      ,.lce_req_addr_i(lce_req_addr_i)
      ,.lce_req_yumi_o(lce_req_yumi_o)
      ,.lce_cmd_v_o(lce_cmd_v_o)
      ,.lce_cmd_ready_i(lce_cmd_ready_i)
      ,.lce_cmd_dst_o(lce_cmd_dst_o)
      ,.lce_cmd_type_o(lce_cmd_type_o)
      ,.lce_cmd_addr_o(lce_cmd_addr_o)
      ,.lce_cmd_state_o(lce_cmd_state_o)
      );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string what);
    $display("%0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_cmd_type(input string name, input lce_cmd_e got, input lce_cmd_e want);
    if (got !== want) begin
      $display("error: time %0t signal %s got %s expected %s", $time, name, got.name(),
               want.name());
      abort_run("command type mismatch");
    end
  endtask

  task automatic verify_state(input string name, input coh_state_e got, input coh_state_e want);
    if (got !== want) begin
      $display("error: time %0t signal %s got %s expected %s", $time, name, got.name(),
               want.name());
      abort_run("coherence state mismatch");
    end
  endtask

  task automatic match_lce_id(input string name, input logic [lce_id_width_lp-1:0] got,
                              input logic [lce_id_width_lp-1:0] want);
    if (got !== want) begin
      $display("error: time %0t signal %s got %0d expected %0d", $time, name, got, want);
      abort_run("LCE id mismatch");
    end
  endtask

  task automatic compare_addr(input string name, input logic [addr_width_lp-1:0] got,
                              input logic [addr_width_lp-1:0] want);
    if (got !== want) begin
      $display("error: time %0t signal %s got %h expected %h", $time, name, got, want);
      abort_run("address mismatch");
    end
  endtask

  // Presents one request and returns once the DUT has consumed it
  task automatic drive_request(input logic [lce_id_width_lp-1:0] lce, input req_type_e rtype,
                               input logic [addr_width_lp-1:0] addr);
    int cycles;
    bit consumed;
    cycles   = 0;
    consumed = 1'b0;
    @(negedge clk_i);
    lce_req_v_i    = 1'b1;
    lce_req_lce_i  = lce;
    lce_req_type_i = rtype;
    lce_req_addr_i = addr;
    while (!consumed) begin
      @(posedge clk_i);
      if (lce_req_yumi_o) begin
        consumed = 1'b1;
      end else begin
        cycles++;
        if (cycles > timeout_lp) begin
          abort_run("timeout waiting for the request to be consumed");
        end
      end
    end
  endtask

  task automatic idle_request();
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (exp_q.size() != 0 || lce_cmd_v_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > timeout_lp) begin
        abort_run("timeout waiting for the expected commands to transfer");
      end
    end
  endtask

  // Ready pattern, random only once back-pressure is switched on
  always @(negedge clk_i) begin
    if (random_ready) begin
      ready_state = lcg_next(ready_state);
      lce_cmd_ready_i = ready_state[19];
    end else begin
      lce_cmd_ready_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin : cmd_checker
    exp_list_t new_cmds;
    exp_cmd_t  exp_cmd;
    if (arst_n_i) begin
      if (lce_req_yumi_o && !lce_req_v_i) begin
        abort_run("yumi raised while no request was valid");
      end
      // Fields must not move while the command waits for ready
      if (hold_pending) begin
        if (!lce_cmd_v_o) begin
          abort_run("command valid dropped before ready was seen");
        end
        check_cmd_type("lce_cmd_type_o", lce_cmd_type_o, held.cmd_type);
        match_lce_id("lce_cmd_dst_o", lce_cmd_dst_o, held.dst);
        compare_addr("lce_cmd_addr_o", lce_cmd_addr_o, held.addr);
        verify_state("lce_cmd_state_o", lce_cmd_state_o, held.state);
      end
      if (lce_cmd_v_o && exp_q.size() == 0) begin
        abort_run("command valid while no command was expected");
      end
      if (lce_cmd_v_o && lce_cmd_ready_i) begin
        exp_cmd = exp_q.pop_front();
        check_cmd_type("lce_cmd_type_o", lce_cmd_type_o, exp_cmd.cmd_type);
        match_lce_id("lce_cmd_dst_o", lce_cmd_dst_o, exp_cmd.dst);
        compare_addr("lce_cmd_addr_o", lce_cmd_addr_o, exp_cmd.addr);
        verify_state("lce_cmd_state_o", lce_cmd_state_o, exp_cmd.state);
      end
      hold_pending  = lce_cmd_v_o && !lce_cmd_ready_i;
      held.cmd_type = lce_cmd_type_o;
      held.dst      = lce_cmd_dst_o;
      held.addr     = lce_cmd_addr_o;
      held.state    = lce_cmd_state_o;
      if (lce_req_yumi_o) begin
        new_cmds = expand_request(lce_req_lce_i, lce_req_type_i, lce_req_addr_i);
        foreach (new_cmds[i]) begin
          exp_q.push_back(new_cmds[i]);
        end
      end
    end else begin
      hold_pending = 1'b0;
    end
  end

  initial begin
    logic [lce_id_width_lp-1:0] lce;
    req_type_e                  rtype;
    arst_n_i        = 1'b0;
    lce_req_v_i     = 1'b0;
    lce_req_lce_i   = '0;
    lce_req_type_i  = e_req_rd;
    lce_req_addr_i  = '0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Idle engine, the checker flags any valid or yumi here
    repeat (12) @(negedge clk_i);

    drive_request(2'd2, e_req_rd, 32'h1000_0040);
    idle_request();
    wait_drain();
    drive_request(2'd0, e_req_wr, 32'h2000_0080);
    idle_request();
    wait_drain();
    drive_request(2'd3, e_req_wr, 32'h3000_00c0);
    idle_request();
    wait_drain();

    @(posedge clk_i);
    random_ready = 1'b1;
    for (int n = 0; n < num_random_lp; n++) begin
      stim_state = lcg_next(stim_state);
      lce        = stim_state[17:16];
      rtype      = req_type_e'(stim_state[23]);
      stim_state = lcg_next(stim_state);
      drive_request(lce, rtype, {stim_state[31:8], 8'h00});
    end
    idle_request();
    wait_drain();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
